//--- tb.f
hdl/csr_map_pkg.sv
hdl/csr_exc_pkg.sv
hdl/csr_ctrl.sv
hdl/csr_exc_state.sv
hdl/csr_timer.sv
hdl/csr_save_bank.sv
hdl/csr_top.sv
testbench/csr_props.sv
testbench/csr_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the csr testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module csr_tb -Mdir obj_dir -o csr_sim -f tb.f \
    && ./obj_dir/csr_sim > sim.log 2>&1 \
    || { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q '^>>> PASS$' sim.log \
    && echo "simulation result found in sim.log" \
    || { echo "no pass line in sim.log"; exit 1; }

//--- testbench/csr_tb.sv
`timescale 1ns/1ns
`default_nettype none

module csr_tb;

    localparam int N_TESTS    = 6;
    localparam int N_OPS      = 24;
    localparam int TIMER_RUN  = 80;  // 8 * largest n + 6 rounded up
    localparam int TIMEOUT_NS = N_TESTS * N_OPS * TIMER_RUN * 40;

    logic                          clk;
    logic                          rst;
    csr_map_pkg::csr_num_t         csr_num;
    logic                          csr_we;
    csr_exc_pkg::word_t            csr_wmask;
    csr_exc_pkg::word_t            csr_wvalue;
    logic                          wb_ex;
    csr_exc_pkg::ecode_t           wb_ecode;
    csr_exc_pkg::esubcode_t        wb_esubcode;
    csr_exc_pkg::word_t            wb_pc;
    logic                          ertn_flush;
    csr_exc_pkg::word_t            csr_rvalue;
    csr_exc_pkg::word_t            ex_entry;
    csr_exc_pkg::word_t            ertn_pc;
    logic                          has_int;
    logic [csr_map_pkg::PLV_W-1:0] crmd_plv;

    // reference model state
    logic [1:0]             m_plv, m_pplv, m_swi;
    logic                   m_ie, m_pie, m_en, m_per, m_flag;
    logic [12:0]            m_lie;
    csr_exc_pkg::ecode_t    m_ecode;
    csr_exc_pkg::esubcode_t m_esub;
    csr_exc_pkg::word_t     m_era, m_tval;
    csr_exc_pkg::word_t     m_save [4];
    logic [25:0]            m_eva;
    logic [29:0]            m_init;

    csr_map_pkg::csr_num_t field_regs [4] = '{csr_map_pkg::CSR_CRMD, csr_map_pkg::CSR_PRMD,
                                              csr_map_pkg::CSR_ECFG, csr_map_pkg::CSR_EENTRY};
    csr_map_pkg::csr_num_t irq_regs [4] = '{csr_map_pkg::CSR_ECFG, csr_map_pkg::CSR_ESTAT,
                                            csr_map_pkg::CSR_CRMD, csr_map_pkg::CSR_ESTAT};

    logic [31:0] lfsr = 32'd22;
    int          errors;
    int          test_errors;
    int          tests_done;
    string       test_name;

    csr_top uut (
        .clk(clk), .rst(rst), .csr_num(csr_num), .csr_we(csr_we),
        .csr_wmask(csr_wmask), .csr_wvalue(csr_wvalue),
        .wb_ex(wb_ex), .wb_ecode(wb_ecode), .wb_esubcode(wb_esubcode), .wb_pc(wb_pc),
        .ertn_flush(ertn_flush), .csr_rvalue(csr_rvalue), .ex_entry(ex_entry),
        .ertn_pc(ertn_pc), .has_int(has_int), .crmd_plv(crmd_plv)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    initial begin
        #(TIMEOUT_NS);
        $display("timeout after %0d ns, the tests did not finish", TIMEOUT_NS);
        $display(">>> FAIL");
        $finish;
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic csr_exc_pkg::word_t model_read(csr_map_pkg::csr_num_t num);
        csr_exc_pkg::word_t r;
        case (num)
            csr_map_pkg::CSR_CRMD:   r = {28'b0, 1'b1, m_ie, m_plv};  // DA fixed at 1
            csr_map_pkg::CSR_PRMD:   r = {29'b0, m_pie, m_pplv};
            csr_map_pkg::CSR_ECFG:   r = {19'b0, m_lie};
            csr_map_pkg::CSR_ESTAT:  r = {1'b0, m_esub, m_ecode, 3'b0, 1'b0, m_flag, 9'b0, m_swi};
            csr_map_pkg::CSR_ERA:    r = m_era;
            csr_map_pkg::CSR_EENTRY: r = {m_eva, 6'b0};
            csr_map_pkg::CSR_SAVE0, csr_map_pkg::CSR_SAVE1,
            csr_map_pkg::CSR_SAVE2, csr_map_pkg::CSR_SAVE3: r = m_save[num[1:0]];
            csr_map_pkg::CSR_TCFG:   r = {m_init, m_per, m_en};
            csr_map_pkg::CSR_TVAL:   r = m_tval;
            default:                 r = '0;
        endcase
        return r;
    endfunction

    function automatic logic model_has_int();
        logic [11:0] is_used;
        is_used = {m_flag, 9'b0, m_swi};
        return (|(is_used & m_lie[11:0])) & m_ie;
    endfunction

    // model steps on the same edge as the DUT from the inputs it sees
    always @(posedge clk) begin : model_step
        csr_exc_pkg::word_t w;
        csr_exc_pkg::word_t tval_n;
        logic               flag_n;
        w = (csr_wvalue & csr_wmask) | (model_read(csr_num) & ~csr_wmask);
        tval_n = m_tval;
        flag_n = m_flag;
        if (rst) begin
            {m_plv, m_ie, m_pplv, m_pie, m_swi} = '0;
            {m_lie, m_ecode, m_esub, m_era, m_eva} = '0;
            {m_en, m_per, m_init, m_flag} = '0;
            m_tval = csr_map_pkg::TIMER_IDLE;
            for (int i = 0; i < 4; i++)
                m_save[i] = '0;
        end else begin
            if (m_tval == '0)
                flag_n = 1'b1;
            else if (csr_we && csr_num == csr_map_pkg::CSR_TICLR && csr_wmask[0] && csr_wvalue[0])
                flag_n = 1'b0;
            if (csr_we && csr_num == csr_map_pkg::CSR_TCFG && w[0])
                tval_n = {w[31:2], 2'b00};
            else if (m_en && m_tval != csr_map_pkg::TIMER_IDLE)
                tval_n = (m_tval == '0 && m_per) ? {m_init, 2'b00} : m_tval - 1;
            m_tval = tval_n;
            m_flag = flag_n;
            if (wb_ex) begin
                m_pplv  = m_plv;
                m_pie   = m_ie;
                m_plv   = '0;
                m_ie    = 1'b0;
                m_ecode = wb_ecode;
                m_esub  = wb_esubcode;
                m_era   = wb_pc;
            end else if (ertn_flush) begin
                m_plv = m_pplv;
                m_ie  = m_pie;
            end else if (csr_we) begin
                case (csr_num)
                    csr_map_pkg::CSR_CRMD:   {m_ie, m_plv} = w[2:0];
                    csr_map_pkg::CSR_PRMD:   {m_pie, m_pplv} = w[2:0];
                    csr_map_pkg::CSR_ECFG:   m_lie = w[12:0] & csr_map_pkg::LIE_MASK;
                    csr_map_pkg::CSR_ESTAT:  m_swi = w[1:0];
                    csr_map_pkg::CSR_ERA:    m_era = w;
                    csr_map_pkg::CSR_EENTRY: m_eva = w[31:6];
                    csr_map_pkg::CSR_TCFG:   {m_init, m_per, m_en} = w;
                    csr_map_pkg::CSR_SAVE0, csr_map_pkg::CSR_SAVE1,
                    csr_map_pkg::CSR_SAVE2, csr_map_pkg::CSR_SAVE3: m_save[csr_num[1:0]] = w;
                    default: ;
                endcase
            end
        end
    end

    task automatic check_word(input string what, input csr_exc_pkg::word_t exp,
                              input csr_exc_pkg::word_t act);
        if (exp !== act) begin
            $display("mismatch %s expected %h actual %h", what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("mismatch %s expected %b actual %b", what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_plv(input string what, input logic [csr_map_pkg::PLV_W-1:0] exp,
                             input logic [csr_map_pkg::PLV_W-1:0] act);
        if (exp !== act) begin
            $display("mismatch %s expected %0d actual %0d", what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic write_csr(input csr_map_pkg::csr_num_t num, input csr_exc_pkg::word_t mask,
                             input csr_exc_pkg::word_t value);
        @(posedge clk);
        csr_num    <= num;
        csr_we     <= 1'b1;
        csr_wmask  <= mask;
        csr_wvalue <= value;
        wb_ex      <= 1'b0;
        ertn_flush <= 1'b0;
    endtask

    task automatic raise_exception();
        @(posedge clk);
        csr_we      <= 1'b0;
        wb_ex       <= 1'b1;
        wb_ecode    <= csr_exc_pkg::ecode_t'(rand_bits(6));
        wb_esubcode <= csr_exc_pkg::esubcode_t'(rand_bits(9));
        wb_pc       <= rand_bits(32);
        ertn_flush  <= 1'b0;
    endtask

    task automatic return_exception();
        @(posedge clk);
        csr_we     <= 1'b0;
        wb_ex      <= 1'b0;
        ertn_flush <= 1'b1;
    endtask

    // one idle cycle then every output against the model
    task automatic read_check(input csr_map_pkg::csr_num_t num);
        @(posedge clk);
        csr_num    <= num;
        csr_we     <= 1'b0;
        wb_ex      <= 1'b0;
        ertn_flush <= 1'b0;
        @(negedge clk);
        check_word($sformatf("%s csr %03h", test_name, num), model_read(num), csr_rvalue);
        check_word({test_name, " ex_entry"}, {m_eva, 6'b0}, ex_entry);
        check_word({test_name, " ertn_pc"}, m_era, ertn_pc);
        check_bit({test_name, " has_int"}, model_has_int(), has_int);
        check_plv({test_name, " crmd_plv"}, m_plv, crmd_plv);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_done++;
        $display("test %-10s %s, %0d errors", test_name,
                 test_errors == 0 ? "ok" : "failed", test_errors);
    endtask

    initial begin
        csr_map_pkg::csr_num_t num;
        int                    n;
        rst         <= 1'b1;
        csr_num     <= '0;
        csr_we      <= 1'b0;
        csr_wmask   <= '0;
        csr_wvalue  <= '0;
        wb_ex       <= 1'b0;
        wb_ecode    <= '0;
        wb_esubcode <= '0;
        wb_pc       <= '0;
        ertn_flush  <= 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        start_test("save_era");
        for (int i = 0; i < N_OPS; i++) begin
            if (i % 5 == 4)
                num = csr_map_pkg::CSR_ERA;
            else
                num = csr_map_pkg::CSR_SAVE0 + csr_map_pkg::csr_num_t'(rand_bits(2));
            write_csr(num, rand_bits(32), rand_bits(32));
            read_check(num);
        end
        finish_test();

        start_test("fields");
        for (int i = 0; i < N_OPS; i++) begin
            num = field_regs[2'(rand_bits(2))];
            write_csr(num, rand_bits(32), rand_bits(32));
            read_check(num);
        end
        finish_test();

        // software interrupt 0 pending and enabled so entry has to mask it
        start_test("exception");
        write_csr(csr_map_pkg::CSR_ECFG, '1, 32'h1);
        write_csr(csr_map_pkg::CSR_ESTAT, '1, 32'h1);
        for (int i = 0; i < N_OPS; i++) begin
            write_csr(csr_map_pkg::CSR_CRMD, rand_bits(32), rand_bits(32));
            raise_exception();
            read_check(csr_map_pkg::CSR_ERA);
            check_plv({test_name, " entry plv"}, 2'b00, crmd_plv);
            check_bit({test_name, " entry has_int"}, 1'b0, has_int);
            read_check(csr_map_pkg::CSR_ESTAT);
            read_check(csr_map_pkg::CSR_PRMD);
            read_check(csr_map_pkg::CSR_CRMD);
        end
        finish_test();

        start_test("return");
        for (int i = 0; i < N_OPS; i++) begin
            if (i % 3 == 0)
                raise_exception();
            write_csr(csr_map_pkg::CSR_PRMD, rand_bits(32), rand_bits(32));
            return_exception();
            read_check(csr_map_pkg::CSR_CRMD);
            check_word({test_name, " restored"}, {29'b0, m_pie, m_pplv}, csr_rvalue & 32'h7);
        end
        finish_test();

        // timer flag routed to has_int through local enable 11
        start_test("timer");
        write_csr(csr_map_pkg::CSR_ECFG, '1, 32'h800);
        write_csr(csr_map_pkg::CSR_ESTAT, '1, 32'h0);
        write_csr(csr_map_pkg::CSR_CRMD, '1, 32'h4);
        for (int i = 0; i < N_OPS / 4; i++) begin
            n = rand_bits(3) + 2;
            write_csr(csr_map_pkg::CSR_TCFG, '1,
                      csr_exc_pkg::word_t'((n << 2) | (rand_bits(1) << 1) | 1));
            for (int k = 0; k < 8 * n + 6; k++) begin
                read_check(csr_map_pkg::CSR_TVAL);
                if (k <= 4 * n)
                    check_word({test_name, " countdown"}, csr_exc_pkg::word_t'(4 * n - k),
                               csr_rvalue);
                if (k == 4 * n + 1)
                    check_bit({test_name, " flag edge"}, 1'b1, has_int);
            end
            write_csr(csr_map_pkg::CSR_TICLR, 32'h1, 32'h1);
            read_check(csr_map_pkg::CSR_ESTAT);
            check_word({test_name, " flag clear"}, '0, csr_rvalue & 32'h800);
        end
        write_csr(csr_map_pkg::CSR_TCFG, '1, '0);
        read_check(csr_map_pkg::CSR_TCFG);
        finish_test();

        start_test("irq");
        for (int i = 0; i < N_OPS; i++) begin
            num = irq_regs[2'(rand_bits(2))];
            write_csr(num, rand_bits(32), rand_bits(32));
            read_check(num);
        end
        finish_test();

        $display("%0d tests run, %0d errors", tests_done, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/csr_props.sv
`timescale 1ns/1ns
`default_nettype none

module csr_props (
    input logic clk,
    input logic rst,
    input logic wb_ex,
    input logic crmd_ie,
    input logic has_int
);

    // entry always turns interrupts off
    a_ex_clears_ie: assert property (@(posedge clk) disable iff (rst) wb_ex |=> !crmd_ie)
        else $error("crmd ie still set one cycle after exception entry");

    a_int_needs_ie: assert property (@(posedge clk) disable iff (rst) has_int |-> crmd_ie)
        else $error("interrupt request while the global enable is clear");

    // first reset edge clears the state, so check from the second one
    a_quiet_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> !has_int)
        else $error("interrupt request during reset");

endmodule

bind csr_exc_state csr_props u_props (
    .clk(clk),
    .rst(rst),
    .wb_ex(wb_ex),
    .crmd_ie(crmd_ie),
    .has_int(has_int)
);

`default_nettype wire

//--- hdl/csr_top.sv
`timescale 1ns/1ns
`default_nettype none

module csr_top (
    input  logic                                 clk,
    input  logic                                 rst,
    input  csr_map_pkg::csr_num_t                csr_num,
    input  logic                                 csr_we,
    input  csr_exc_pkg::word_t                   csr_wmask,
    input  csr_exc_pkg::word_t                   csr_wvalue,
    input  logic                                 wb_ex,
    input  csr_exc_pkg::ecode_t                  wb_ecode,
    input  csr_exc_pkg::esubcode_t               wb_esubcode,
    input  csr_exc_pkg::word_t                   wb_pc,
    input  logic                                 ertn_flush,
    output csr_exc_pkg::word_t                   csr_rvalue,
    output csr_exc_pkg::word_t                   ex_entry,
    output csr_exc_pkg::word_t                   ertn_pc,
    output logic                                 has_int,
    output logic [csr_map_pkg::PLV_W-1:0]        crmd_plv
);

    // write strobes from decode
    logic crmd_we, prmd_we, ecfg_we, estat_we, era_we, eentry_we;
    logic tcfg_we, ticlr_we;
    logic [csr_map_pkg::SAVE_NUM-1:0] save_we;

    // read words back to the mux
    csr_exc_pkg::word_t crmd_rvalue, prmd_rvalue, ecfg_rvalue, estat_rvalue;
    csr_exc_pkg::word_t era_rvalue, eentry_rvalue, tcfg_rvalue, tval_rvalue;
    csr_exc_pkg::word_t [csr_map_pkg::SAVE_NUM-1:0] save_rvalue;

    logic timer_int;

    csr_ctrl u_ctrl (
        .csr_num(csr_num), .csr_we(csr_we),
        .crmd_rvalue(crmd_rvalue), .prmd_rvalue(prmd_rvalue),
        .ecfg_rvalue(ecfg_rvalue), .estat_rvalue(estat_rvalue),
        .era_rvalue(era_rvalue), .eentry_rvalue(eentry_rvalue),
        .save_rvalue(save_rvalue), .tcfg_rvalue(tcfg_rvalue), .tval_rvalue(tval_rvalue),
        .crmd_we(crmd_we), .prmd_we(prmd_we), .ecfg_we(ecfg_we), .estat_we(estat_we),
        .era_we(era_we), .eentry_we(eentry_we), .save_we(save_we),
        .tcfg_we(tcfg_we), .ticlr_we(ticlr_we), .csr_rvalue(csr_rvalue)
    );

    csr_exc_state u_exc_state (
        .clk(clk), .rst(rst),
        .crmd_we(crmd_we), .prmd_we(prmd_we), .ecfg_we(ecfg_we), .estat_we(estat_we),
        .era_we(era_we), .eentry_we(eentry_we),
        .csr_wmask(csr_wmask), .csr_wvalue(csr_wvalue),
        .wb_ex(wb_ex), .wb_ecode(wb_ecode), .wb_esubcode(wb_esubcode), .wb_pc(wb_pc),
        .ertn_flush(ertn_flush), .timer_int(timer_int),
        .crmd_rvalue(crmd_rvalue), .prmd_rvalue(prmd_rvalue),
        .ecfg_rvalue(ecfg_rvalue), .estat_rvalue(estat_rvalue),
        .era_rvalue(era_rvalue), .eentry_rvalue(eentry_rvalue),
        .ex_entry(ex_entry), .ertn_pc(ertn_pc), .has_int(has_int), .crmd_plv(crmd_plv)
    );

    csr_timer u_timer (
        .clk(clk), .rst(rst),
        .tcfg_we(tcfg_we), .ticlr_we(ticlr_we),
        .csr_wmask(csr_wmask), .csr_wvalue(csr_wvalue),
        .tcfg_rvalue(tcfg_rvalue), .tval_rvalue(tval_rvalue), .timer_int(timer_int)
    );

    csr_save_bank u_save_bank (
        .clk(clk), .rst(rst),
        .save_we(save_we), .csr_wmask(csr_wmask), .csr_wvalue(csr_wvalue),
        .save_rvalue(save_rvalue)
    );

endmodule

`default_nettype wire

//--- hdl/csr_save_bank.sv
`timescale 1ns/1ns
`default_nettype none

module csr_save_bank (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic [csr_map_pkg::SAVE_NUM-1:0]                 save_we,
    input  csr_exc_pkg::word_t                               csr_wmask,
    input  csr_exc_pkg::word_t                               csr_wvalue,
    output csr_exc_pkg::word_t [csr_map_pkg::SAVE_NUM-1:0]   save_rvalue
);

    // scratch words for the exception handler
    always_ff @(posedge clk) begin
        for (int i = 0; i < csr_map_pkg::SAVE_NUM; i++) begin
            if (rst)
                save_rvalue[i] <= '0;
            else if (save_we[i])
                save_rvalue[i] <= (csr_wvalue & csr_wmask) | (save_rvalue[i] & ~csr_wmask);
        end
    end

endmodule

`default_nettype wire

//--- hdl/csr_timer.sv
`timescale 1ns/1ns
`default_nettype none

module csr_timer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  tcfg_we,
    input  logic                  ticlr_we,
    input  csr_exc_pkg::word_t    csr_wmask,
    input  csr_exc_pkg::word_t    csr_wvalue,
    output csr_exc_pkg::word_t    tcfg_rvalue,
    output csr_exc_pkg::word_t    tval_rvalue,
    output logic                  timer_int
);

    logic                                  tcfg_en;
    logic                                  tcfg_periodic;
    logic [csr_map_pkg::TCFG_INIT_W-1:0]   tcfg_initval;
    csr_exc_pkg::word_t                    tval;
    csr_exc_pkg::word_t                    tcfg_wr;
    logic                                  tval_zero;
    logic                                  clr_req;

    assign tcfg_rvalue = {tcfg_initval, tcfg_periodic, tcfg_en};
    assign tcfg_wr     = (csr_wvalue & csr_wmask) | (tcfg_rvalue & ~csr_wmask);
    assign tval_zero   = (tval == '0);
    assign clr_req     = ticlr_we && csr_wmask[csr_map_pkg::TICLR_CLR]
                         && csr_wvalue[csr_map_pkg::TICLR_CLR];

    always_ff @(posedge clk) begin
        if (rst) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else if (tcfg_we) begin
            tcfg_en       <= tcfg_wr[csr_map_pkg::TCFG_EN];
            tcfg_periodic <= tcfg_wr[csr_map_pkg::TCFG_PERIODIC];
            tcfg_initval  <= tcfg_wr[csr_map_pkg::TCFG_INIT_LSB +: csr_map_pkg::TCFG_INIT_W];
        end
    end

    // countdown, loaded from the merged word so an enabling write starts it at once
    always_ff @(posedge clk) begin
        if (rst)
            tval <= csr_map_pkg::TIMER_IDLE;
        else if (tcfg_we && tcfg_wr[csr_map_pkg::TCFG_EN])
            tval <= {tcfg_wr[csr_map_pkg::TCFG_INIT_LSB +: csr_map_pkg::TCFG_INIT_W], 2'b00};
        else if (tcfg_en && tval != csr_map_pkg::TIMER_IDLE) begin
            if (tval_zero && tcfg_periodic)
                tval <= {tcfg_initval, 2'b00};  // initial value times 4
            else
                tval <= tval - 32'd1;  // one-shot wraps to idle
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            timer_int <= 1'b0;
        else if (tval_zero)
            timer_int <= 1'b1;  // set wins over clear
        else if (clr_req)
            timer_int <= 1'b0;
    end

    assign tval_rvalue = tval;

endmodule

`default_nettype wire

//--- hdl/csr_exc_state.sv
`timescale 1ns/1ns
`default_nettype none

module csr_exc_state (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              crmd_we,
    input  logic                              prmd_we,
    input  logic                              ecfg_we,
    input  logic                              estat_we,
    input  logic                              era_we,
    input  logic                              eentry_we,
    input  csr_exc_pkg::word_t                csr_wmask,
    input  csr_exc_pkg::word_t                csr_wvalue,
    input  logic                              wb_ex,
    input  csr_exc_pkg::ecode_t               wb_ecode,
    input  csr_exc_pkg::esubcode_t            wb_esubcode,
    input  csr_exc_pkg::word_t                wb_pc,
    input  logic                              ertn_flush,
    input  logic                              timer_int,
    output csr_exc_pkg::word_t                crmd_rvalue,
    output csr_exc_pkg::word_t                prmd_rvalue,
    output csr_exc_pkg::word_t                ecfg_rvalue,
    output csr_exc_pkg::word_t                estat_rvalue,
    output csr_exc_pkg::word_t                era_rvalue,
    output csr_exc_pkg::word_t                eentry_rvalue,
    output csr_exc_pkg::word_t                ex_entry,
    output csr_exc_pkg::word_t                ertn_pc,
    output logic                              has_int,
    output logic [csr_map_pkg::PLV_W-1:0]     crmd_plv
);

    logic                                   crmd_ie;
    logic [csr_map_pkg::PLV_W-1:0]          prmd_pplv;
    logic                                   prmd_pie;
    logic [csr_map_pkg::LIE_W-1:0]          ecfg_lie;
    logic [csr_map_pkg::SWI_W-1:0]          estat_swi;
    csr_exc_pkg::ecode_t                    estat_ecode;
    csr_exc_pkg::esubcode_t                 estat_esubcode;
    csr_exc_pkg::word_t                     era_pc;
    logic [csr_map_pkg::EENTRY_VA_W-1:0]    eentry_va;
    logic [csr_exc_pkg::IS_W-1:0]           estat_is;

    // masked merge of each register's current read word
    csr_exc_pkg::word_t crmd_wr, prmd_wr, ecfg_wr, estat_wr, era_wr, eentry_wr;
    assign crmd_wr   = (csr_wvalue & csr_wmask) | (crmd_rvalue & ~csr_wmask);
    assign prmd_wr   = (csr_wvalue & csr_wmask) | (prmd_rvalue & ~csr_wmask);
    assign ecfg_wr   = (csr_wvalue & csr_wmask) | (ecfg_rvalue & ~csr_wmask);
    assign estat_wr  = (csr_wvalue & csr_wmask) | (estat_rvalue & ~csr_wmask);
    assign era_wr    = (csr_wvalue & csr_wmask) | (era_rvalue & ~csr_wmask);
    assign eentry_wr = (csr_wvalue & csr_wmask) | (eentry_rvalue & ~csr_wmask);

    // exception beats return, return beats csr write
    always_ff @(posedge clk) begin
        if (rst) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (wb_ex) begin
            crmd_plv <= '0;  // enter kernel, interrupts off
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (crmd_we) begin
            crmd_plv <= crmd_wr[csr_map_pkg::PLV_W-1:0];
            crmd_ie  <= crmd_wr[csr_map_pkg::CRMD_IE];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (wb_ex) begin
            prmd_pplv <= crmd_plv;  // save mode at entry
            prmd_pie  <= crmd_ie;
        end else if (prmd_we) begin
            prmd_pplv <= prmd_wr[csr_map_pkg::PLV_W-1:0];
            prmd_pie  <= prmd_wr[csr_map_pkg::PRMD_PIE];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ecfg_lie       <= '0;
            estat_swi      <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            era_pc         <= '0;
            eentry_va      <= '0;
        end else begin
            if (ecfg_we)
                ecfg_lie <= ecfg_wr[csr_map_pkg::LIE_W-1:0] & csr_map_pkg::LIE_MASK;
            if (estat_we)
                estat_swi <= estat_wr[csr_exc_pkg::INT_SWI_LO +: csr_map_pkg::SWI_W];
            if (wb_ex) begin
                estat_ecode    <= wb_ecode;
                estat_esubcode <= wb_esubcode;
                era_pc         <= wb_pc;
            end else if (era_we) begin
                era_pc <= era_wr;
            end
            if (eentry_we)
                eentry_va <= eentry_wr[csr_map_pkg::EENTRY_VA_LSB +: csr_map_pkg::EENTRY_VA_W];
        end
    end

    always_comb begin
        estat_is = '0;  // hw and ipi lines not connected
        estat_is[csr_exc_pkg::INT_SWI_LO +: csr_map_pkg::SWI_W] = estat_swi;
        estat_is[csr_exc_pkg::INT_TIMER] = timer_int;
    end

    always_comb begin
        crmd_rvalue = '0;
        crmd_rvalue[csr_map_pkg::PLV_W-1:0] = crmd_plv;
        crmd_rvalue[csr_map_pkg::CRMD_IE] = crmd_ie;
        crmd_rvalue[csr_map_pkg::CRMD_DA] = 1'b1;  // direct translation only
        prmd_rvalue = '0;
        prmd_rvalue[csr_map_pkg::PLV_W-1:0] = prmd_pplv;
        prmd_rvalue[csr_map_pkg::PRMD_PIE] = prmd_pie;
    end

    assign ecfg_rvalue   = {19'b0, ecfg_lie};
    assign estat_rvalue  = {1'b0, estat_esubcode, estat_ecode, 3'b0, estat_is};
    assign era_rvalue    = era_pc;
    assign eentry_rvalue = {eentry_va, {csr_map_pkg::EENTRY_VA_LSB{1'b0}}};

    assign ex_entry = eentry_rvalue;
    assign ertn_pc  = era_pc;

    // local enables first, then global IE
    assign has_int = (|(estat_is[csr_exc_pkg::INT_USED_W-1:0]
                        & ecfg_lie[csr_exc_pkg::INT_USED_W-1:0])) & crmd_ie;

endmodule

`default_nettype wire

//--- hdl/csr_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module csr_ctrl (
    input  csr_map_pkg::csr_num_t                            csr_num,
    input  logic                                             csr_we,
    input  csr_exc_pkg::word_t                               crmd_rvalue,
    input  csr_exc_pkg::word_t                               prmd_rvalue,
    input  csr_exc_pkg::word_t                               ecfg_rvalue,
    input  csr_exc_pkg::word_t                               estat_rvalue,
    input  csr_exc_pkg::word_t                               era_rvalue,
    input  csr_exc_pkg::word_t                               eentry_rvalue,
    input  csr_exc_pkg::word_t [csr_map_pkg::SAVE_NUM-1:0]   save_rvalue,
    input  csr_exc_pkg::word_t                               tcfg_rvalue,
    input  csr_exc_pkg::word_t                               tval_rvalue,
    output logic                                             crmd_we,
    output logic                                             prmd_we,
    output logic                                             ecfg_we,
    output logic                                             estat_we,
    output logic                                             era_we,
    output logic                                             eentry_we,
    output logic [csr_map_pkg::SAVE_NUM-1:0]                 save_we,
    output logic                                             tcfg_we,
    output logic                                             ticlr_we,
    output csr_exc_pkg::word_t                               csr_rvalue
);

    // one strobe per register, only while an instruction writes
    assign crmd_we   = csr_we && (csr_num == csr_map_pkg::CSR_CRMD);
    assign prmd_we   = csr_we && (csr_num == csr_map_pkg::CSR_PRMD);
    assign ecfg_we   = csr_we && (csr_num == csr_map_pkg::CSR_ECFG);
    assign estat_we  = csr_we && (csr_num == csr_map_pkg::CSR_ESTAT);
    assign era_we    = csr_we && (csr_num == csr_map_pkg::CSR_ERA);
    assign eentry_we = csr_we && (csr_num == csr_map_pkg::CSR_EENTRY);
    assign tcfg_we   = csr_we && (csr_num == csr_map_pkg::CSR_TCFG);
    assign ticlr_we  = csr_we && (csr_num == csr_map_pkg::CSR_TICLR);

    assign save_we = {csr_we && (csr_num == csr_map_pkg::CSR_SAVE3),
                      csr_we && (csr_num == csr_map_pkg::CSR_SAVE2),
                      csr_we && (csr_num == csr_map_pkg::CSR_SAVE1),
                      csr_we && (csr_num == csr_map_pkg::CSR_SAVE0)};

    // combinational read, no enable needed
    always_comb begin
        case (csr_num)
            csr_map_pkg::CSR_CRMD:   csr_rvalue = crmd_rvalue;
            csr_map_pkg::CSR_PRMD:   csr_rvalue = prmd_rvalue;
            csr_map_pkg::CSR_ECFG:   csr_rvalue = ecfg_rvalue;
            csr_map_pkg::CSR_ESTAT:  csr_rvalue = estat_rvalue;
            csr_map_pkg::CSR_ERA:    csr_rvalue = era_rvalue;
            csr_map_pkg::CSR_EENTRY: csr_rvalue = eentry_rvalue;
            csr_map_pkg::CSR_SAVE0:  csr_rvalue = save_rvalue[0];
            csr_map_pkg::CSR_SAVE1:  csr_rvalue = save_rvalue[1];
            csr_map_pkg::CSR_SAVE2:  csr_rvalue = save_rvalue[2];
            csr_map_pkg::CSR_SAVE3:  csr_rvalue = save_rvalue[3];
            csr_map_pkg::CSR_TCFG:   csr_rvalue = tcfg_rvalue;
            csr_map_pkg::CSR_TVAL:   csr_rvalue = tval_rvalue;
            csr_map_pkg::CSR_TICLR:  csr_rvalue = '0;   // clear bit is write-only
            default:                 csr_rvalue = '0;   // unmapped
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/csr_exc_pkg.sv
`default_nettype none

package csr_exc_pkg;

    typedef logic [31:0] word_t;
    typedef logic [5:0]  ecode_t;     // primary exception code
    typedef logic [8:0]  esubcode_t;  // secondary code

    // interrupt status layout
    localparam int IS_W       = 13;
    localparam int INT_SWI_LO = 0;    // two software bits from here
    localparam int INT_TIMER  = 11;

    // bits 11..0 feed the request, bit 12 (ipi) is not wired
    localparam int INT_USED_W = 12;

endpackage

`default_nettype wire

//--- hdl/csr_map_pkg.sv
`default_nettype none

package csr_map_pkg;

    typedef logic [13:0] csr_num_t;

    // register numbers
    localparam csr_num_t CSR_CRMD   = 14'h000;
    localparam csr_num_t CSR_PRMD   = 14'h001;
    localparam csr_num_t CSR_ECFG   = 14'h004;
    localparam csr_num_t CSR_ESTAT  = 14'h005;
    localparam csr_num_t CSR_ERA    = 14'h006;
    localparam csr_num_t CSR_EENTRY = 14'h00c;
    localparam csr_num_t CSR_SAVE0  = 14'h030;
    localparam csr_num_t CSR_SAVE1  = 14'h031;
    localparam csr_num_t CSR_SAVE2  = 14'h032;
    localparam csr_num_t CSR_SAVE3  = 14'h033;
    localparam csr_num_t CSR_TCFG   = 14'h041;
    localparam csr_num_t CSR_TVAL   = 14'h042;
    localparam csr_num_t CSR_TICLR  = 14'h044;

    // field widths
    localparam int PLV_W       = 2;
    localparam int LIE_W       = 13;
    localparam int SWI_W       = 2;
    localparam int EENTRY_VA_W = 26;
    localparam int TCFG_INIT_W = 30;

    localparam logic [LIE_W-1:0] LIE_MASK = 13'h1bff;   // bit 10 not implemented

    // single-bit field positions
    localparam int CRMD_IE       = 2;
    localparam int CRMD_DA       = 3;
    localparam int PRMD_PIE      = 2;
    localparam int TCFG_EN       = 0;
    localparam int TCFG_PERIODIC = 1;
    localparam int TICLR_CLR     = 0;

    // low end of multi-bit fields
    localparam int EENTRY_VA_LSB = 6;
    localparam int TCFG_INIT_LSB = 2;

    localparam logic [31:0] TIMER_IDLE = 32'hffff_ffff;   // stopped countdown

    localparam int SAVE_NUM = 4;

endpackage

`default_nettype wire
